// ==== Bender.yml ====
package:
  name: idStage

sources:
  - common/idPkg.sv
  - hw/decode/instDecoder.sv
  - hw/decode/branchResolver.sv
  - hw/operandStage.sv
  - hw/idStage.sv
  - target: test
    files:
      - test/idStage_sva.sv
      - test/idStageTb.sv

// ==== common/idPkg.sv ====
`default_nettype none

package idPkg;

    localparam int wordW     = 32;
    localparam int regAddrW  = 5;
    localparam int opcodeW   = 6;
    localparam int functW    = 6;
    localparam int exOpW     = 5;
    localparam int jumpKindW = 3;

    typedef logic [wordW-1:0]     wordT;
    typedef logic [regAddrW-1:0]  regAddrT;
    typedef logic [opcodeW-1:0]   opcodeT;
    typedef logic [functW-1:0]    functT;
    typedef logic [exOpW-1:0]     exOpT;
    typedef logic [jumpKindW-1:0] jumpKindT;

    // primary opcode field, bits 31..26
    localparam opcodeT opSpecial = 6'd0;
    localparam opcodeT opRegimm  = 6'd1;   // only bltz is decoded here
    localparam opcodeT opJ       = 6'd2;
    localparam opcodeT opJal     = 6'd3;
    localparam opcodeT opBeq     = 6'd4;
    localparam opcodeT opBne     = 6'd5;
    localparam opcodeT opBgtz    = 6'd7;
    localparam opcodeT opAddi    = 6'd8;
    localparam opcodeT opAndi    = 6'd12;
    localparam opcodeT opOri     = 6'd13;
    localparam opcodeT opXori    = 6'd14;
    localparam opcodeT opLui     = 6'd15;
    localparam opcodeT opLw      = 6'd35;
    localparam opcodeT opSw      = 6'd43;

    // function field under opSpecial, bits 5..0
    localparam functT fnSll  = 6'd0;
    localparam functT fnSrl  = 6'd2;
    localparam functT fnSra  = 6'd3;
    localparam functT fnJr   = 6'd8;
    localparam functT fnJalr = 6'd9;
    localparam functT fnAdd  = 6'd32;
    localparam functT fnSub  = 6'd34;
    localparam functT fnAnd  = 6'd36;
    localparam functT fnOr   = 6'd37;
    localparam functT fnXor  = 6'd38;
    localparam functT fnSlt  = 6'd42;

    localparam exOpT exNop  = 5'd0;
    localparam exOpT exAdd  = 5'd1;
    localparam exOpT exSub  = 5'd2;
    localparam exOpT exAnd  = 5'd3;
    localparam exOpT exOr   = 5'd4;
    localparam exOpT exXor  = 5'd5;
    localparam exOpT exSlt  = 5'd6;
    localparam exOpT exSll  = 5'd7;
    localparam exOpT exSrl  = 5'd8;
    localparam exOpT exSra  = 5'd9;
    localparam exOpT exLui  = 5'd10;
    localparam exOpT exJ    = 5'd11;
    localparam exOpT exJal  = 5'd12;
    localparam exOpT exJr   = 5'd13;
    localparam exOpT exJalr = 5'd14;
    localparam exOpT exLw   = 5'd15;
    localparam exOpT exSw   = 5'd16;
    localparam exOpT exBeq  = 5'd17;
    localparam exOpT exBne  = 5'd18;
    localparam exOpT exBgtz = 5'd19;
    localparam exOpT exBltz = 5'd20;

    localparam jumpKindT jkNone   = 3'd0;
    localparam jumpKindT jkTarget = 3'd1;   // always taken, static target
    localparam jumpKindT jkReg    = 3'd2;   // always taken, register a value
    localparam jumpKindT jkEq     = 3'd3;
    localparam jumpKindT jkNe     = 3'd4;
    localparam jumpKindT jkGtz    = 3'd5;
    localparam jumpKindT jkLtz    = 3'd6;

    localparam regAddrT linkReg = 5'd31;

    typedef struct packed {
        logic    en;
        regAddrT addr;
    } regReadT;

    typedef struct packed {
        exOpT     exOp;
        logic     regaRead;
        logic     regbRead;
        logic     regcWrite;
        regAddrT  regaAddr;
        regAddrT  regbAddr;
        regAddrT  regcAddr;
        wordT     imm;
        jumpKindT jumpKind;
        wordT     target;
    } decodeT;

    typedef struct packed {
        logic jCe;
        wordT jAddr;
    } jumpT;

    typedef struct packed {
        exOpT    exOp;
        wordT    regaData;
        wordT    regbData;
        logic    regcWrite;
        regAddrT regcAddr;
    } exBundleT;

    localparam decodeT nopDecode = '{
        exOp:      exNop,
        regaRead:  1'b0,
        regbRead:  1'b0,
        regcWrite: 1'b0,
        regaAddr:  '0,
        regbAddr:  '0,
        regcAddr:  '0,
        imm:       '0,
        jumpKind:  jkNone,
        target:    '0
    };

    localparam exBundleT nopBundle = '{
        exOp:      exNop,
        regaData:  '0,
        regbData:  '0,
        regcWrite: 1'b0,
        regcAddr:  '0
    };

endpackage

`default_nettype wire

// ==== hw/decode/branchResolver.sv ====
`timescale 1ns/100ps
`default_nettype none

module branchResolver (
    input  idPkg::decodeT dec,
    input  idPkg::wordT   regaRdData,
    input  idPkg::wordT   regbRdData,
    output idPkg::jumpT   jump
);

    logic taken;
    logic regEq;
    logic regaPos;
    logic regaNeg;

    assign regEq   = (regaRdData == regbRdData);
    assign regaPos = $signed(regaRdData) > 32'sd0;   // bgtz and bltz treat the register as signed
    assign regaNeg = $signed(regaRdData) < 32'sd0;

    always_comb
    begin
        case (dec.jumpKind)
            idPkg::jkTarget: taken = 1'b1;
            idPkg::jkReg:    taken = 1'b1;
            idPkg::jkEq:     taken = regEq;
            idPkg::jkNe:     taken = !regEq;
            idPkg::jkGtz:    taken = regaPos;
            idPkg::jkLtz:    taken = regaNeg;
            default:         taken = 1'b0;
        endcase
    end

    assign jump.jCe   = taken;
    assign jump.jAddr = (dec.jumpKind == idPkg::jkReg) ? regaRdData : dec.target;

endmodule

`default_nettype wire

// ==== hw/decode/instDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instDecoder (
    input  logic           rstN,
    input  idPkg::wordT    inst,
    input  idPkg::wordT    pc,
    output idPkg::decodeT  dec,
    output idPkg::regReadT regaReq,
    output idPkg::regReadT regbReq
);

    idPkg::opcodeT  opcode;
    idPkg::functT   funct;
    idPkg::regAddrT rs;
    idPkg::regAddrT rt;
    idPkg::regAddrT rd;
    idPkg::wordT    npc;
    idPkg::wordT    zeroImm;
    idPkg::wordT    signImm;
    idPkg::wordT    shiftImm;
    idPkg::wordT    regionTarget;
    idPkg::wordT    branchTarget;
    idPkg::decodeT  raw;

    function automatic idPkg::exOpT specialOp(input idPkg::functT fn);
        case (fn)
            idPkg::fnAdd:  return idPkg::exAdd;
            idPkg::fnSub:  return idPkg::exSub;
            idPkg::fnAnd:  return idPkg::exAnd;
            idPkg::fnOr:   return idPkg::exOr;
            idPkg::fnXor:  return idPkg::exXor;
            idPkg::fnSlt:  return idPkg::exSlt;
            idPkg::fnSll:  return idPkg::exSll;
            idPkg::fnSrl:  return idPkg::exSrl;
            idPkg::fnSra:  return idPkg::exSra;
            idPkg::fnJr:   return idPkg::exJr;
            idPkg::fnJalr: return idPkg::exJalr;
            default:       return idPkg::exNop;
        endcase
    endfunction

    function automatic idPkg::exOpT immAluOp(input idPkg::opcodeT op);
        case (op)
            idPkg::opAddi: return idPkg::exAdd;
            idPkg::opAndi: return idPkg::exAnd;
            idPkg::opOri:  return idPkg::exOr;
            idPkg::opXori: return idPkg::exXor;
            default:       return idPkg::exNop;
        endcase
    endfunction

    assign opcode   = inst[31:26];
    assign funct    = inst[5:0];
    assign rs       = inst[25:21];
    assign rt       = inst[20:16];
    assign rd       = inst[15:11];
    assign npc      = pc + 32'd4;
    assign zeroImm  = {16'h0, inst[15:0]};
    assign signImm  = {{16{inst[15]}}, inst[15:0]};
    assign shiftImm = {27'h0, inst[10:6]};

    assign regionTarget = {npc[31:28], inst[25:0], 2'b00};
    assign branchTarget = npc + {signImm[29:0], 2'b00};   // word offset from the delay slot

    always_comb
    begin
        raw = idPkg::nopDecode;
        case (opcode)
            idPkg::opSpecial:
            begin
                raw.exOp = specialOp(funct);
                case (funct)
                    idPkg::fnAdd, idPkg::fnSub, idPkg::fnAnd, idPkg::fnOr, idPkg::fnXor,
                    idPkg::fnSlt:
                    begin
                        raw.regaRead  = 1'b1;
                        raw.regbRead  = 1'b1;
                        raw.regcWrite = 1'b1;
                        raw.regcAddr  = rd;
                    end
                    idPkg::fnSll, idPkg::fnSrl, idPkg::fnSra:
                    begin
                        raw.regbRead  = 1'b1;
                        raw.regcWrite = 1'b1;
                        raw.regcAddr  = rd;
                        raw.imm       = shiftImm;   // shift amount goes out as operand a
                    end
                    idPkg::fnJr:
                    begin
                        raw.regaRead = 1'b1;
                        raw.jumpKind = idPkg::jkReg;
                    end
                    idPkg::fnJalr:
                    begin
                        raw.regaRead  = 1'b1;
                        raw.regcWrite = 1'b1;
                        raw.regcAddr  = rd;
                        raw.imm       = npc;
                        raw.jumpKind  = idPkg::jkReg;
                    end
                    default: raw = idPkg::nopDecode;
                endcase
            end
            idPkg::opAddi, idPkg::opAndi, idPkg::opOri, idPkg::opXori:
            begin
                raw.exOp      = immAluOp(opcode);
                raw.regaRead  = 1'b1;
                raw.regcWrite = 1'b1;
                raw.regcAddr  = rt;
                raw.imm       = zeroImm;   // addi is zero-extended too
            end
            idPkg::opLui:
            begin
                raw.exOp      = idPkg::exLui;
                raw.regcWrite = 1'b1;
                raw.regcAddr  = rt;
                raw.imm       = {inst[15:0], 16'h0};
            end
            idPkg::opLw:
            begin
                raw.exOp      = idPkg::exLw;
                raw.regaRead  = 1'b1;
                raw.regcWrite = 1'b1;
                raw.regcAddr  = rt;
                raw.imm       = signImm;
            end
            idPkg::opSw:
            begin
                raw.exOp     = idPkg::exSw;
                raw.regaRead = 1'b1;
                raw.regbRead = 1'b1;   // store data
                raw.imm      = signImm;
            end
            idPkg::opJ:
            begin
                raw.exOp     = idPkg::exJ;
                raw.jumpKind = idPkg::jkTarget;
                raw.target   = regionTarget;
            end
            idPkg::opJal:
            begin
                raw.exOp      = idPkg::exJal;
                raw.regcWrite = 1'b1;
                raw.regcAddr  = idPkg::linkReg;
                raw.imm       = npc;
                raw.jumpKind  = idPkg::jkTarget;
                raw.target    = regionTarget;
            end
            idPkg::opBeq, idPkg::opBne:
            begin
                raw.exOp     = (opcode == idPkg::opBeq) ? idPkg::exBeq : idPkg::exBne;
                raw.regaRead = 1'b1;
                raw.regbRead = 1'b1;
                raw.jumpKind = (opcode == idPkg::opBeq) ? idPkg::jkEq : idPkg::jkNe;
                raw.target   = branchTarget;
            end
            idPkg::opBgtz, idPkg::opRegimm:
            begin
                raw.exOp     = (opcode == idPkg::opBgtz) ? idPkg::exBgtz : idPkg::exBltz;
                raw.regaRead = 1'b1;
                raw.jumpKind = (opcode == idPkg::opBgtz) ? idPkg::jkGtz : idPkg::jkLtz;
                raw.target   = branchTarget;
            end
            default: raw = idPkg::nopDecode;
        endcase
        raw.regaAddr = raw.regaRead ? rs : '0;
        raw.regbAddr = raw.regbRead ? rt : '0;
    end

    assign dec = rstN ? raw : idPkg::nopDecode;   // stage sits at nop while in reset

    assign regaReq = '{en: dec.regaRead, addr: dec.regaAddr};
    assign regbReq = '{en: dec.regbRead, addr: dec.regbAddr};

endmodule

`default_nettype wire

// ==== hw/idStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module idStage (
    input  logic            clk,
    input  logic            rstN,
    input  idPkg::wordT     inst,
    input  idPkg::wordT     pc,
    input  idPkg::wordT     regaRdData,
    input  idPkg::wordT     regbRdData,
    output idPkg::regReadT  regaReq,
    output idPkg::regReadT  regbReq,
    output idPkg::jumpT     jump,
    output idPkg::exBundleT ex
);

    idPkg::decodeT dec;

    instDecoder decoder (
        .rstN    (rstN),
        .inst    (inst),
        .pc      (pc),
        .dec     (dec),
        .regaReq (regaReq),
        .regbReq (regbReq)
    );

    // register values come back from the register file in the same cycle
    branchResolver resolver (
        .dec        (dec),
        .regaRdData (regaRdData),
        .regbRdData (regbRdData),
        .jump       (jump)
    );

    operandStage operands (
        .clk        (clk),
        .rstN       (rstN),
        .dec        (dec),
        .regaRdData (regaRdData),
        .regbRdData (regbRdData),
        .ex         (ex)
    );

endmodule

`default_nettype wire

// ==== hw/operandStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module operandStage (
    input  logic            clk,
    input  logic            rstN,
    input  idPkg::decodeT   dec,
    input  idPkg::wordT     regaRdData,
    input  idPkg::wordT     regbRdData,
    output idPkg::exBundleT ex
);

    logic            isMem;
    idPkg::wordT     regaOperand;
    idPkg::wordT     regbOperand;
    idPkg::exBundleT nextEx;

    assign isMem = (dec.exOp == idPkg::exLw) || (dec.exOp == idPkg::exSw);

    always_comb
    begin
        if (isMem)
            regaOperand = regaRdData + dec.imm;   // effective address is formed here, not in execute
        else if (dec.regaRead)
            regaOperand = regaRdData;
        else
            regaOperand = dec.imm;
    end

    assign regbOperand = dec.regbRead ? regbRdData : dec.imm;

    assign nextEx = '{
        exOp:      dec.exOp,
        regaData:  regaOperand,
        regbData:  regbOperand,
        regcWrite: dec.regcWrite,
        regcAddr:  dec.regcAddr
    };

    always_ff @(posedge clk)
    begin
        if (!rstN)
            ex <= idPkg::nopBundle;
        else
            ex <= nextEx;
    end

endmodule

`default_nettype wire

// ==== idStage.f ====
common/idPkg.sv
hw/decode/instDecoder.sv
hw/decode/branchResolver.sv
hw/operandStage.sv
hw/idStage.sv
test/idStage_sva.sv
test/idStageTb.sv

// ==== test/idStageTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module idStageTb;

    localparam int clkPeriod   = 40;
    localparam int resetCycles = 3;
    localparam int numInst     = 400;

    localparam logic [11*6-1:0] keptFns = {idPkg::fnAdd, idPkg::fnSub, idPkg::fnAnd,
        idPkg::fnOr, idPkg::fnXor, idPkg::fnSlt, idPkg::fnSll, idPkg::fnSrl, idPkg::fnSra,
        idPkg::fnJr, idPkg::fnJalr};
    localparam logic [13*6-1:0] keptOps = {idPkg::opRegimm, idPkg::opJ, idPkg::opJal,
        idPkg::opBeq, idPkg::opBne, idPkg::opBgtz, idPkg::opAddi, idPkg::opAndi, idPkg::opOri,
        idPkg::opXori, idPkg::opLui, idPkg::opLw, idPkg::opSw};
    // encodings outside the decoded set, including the dropped multiply and divide
    localparam logic [8*6-1:0] unusedOps = {6'd6, 6'd9, 6'd10, 6'd11, 6'd16, 6'd32, 6'd40, 6'd63};
    localparam logic [8*6-1:0] unusedFns = {6'd1, 6'd12, 6'd16, 6'd24, 6'd26, 6'd33, 6'd39, 6'd43};

    typedef struct packed {
        idPkg::regReadT  aReq;
        idPkg::regReadT  bReq;
        idPkg::jumpT     jump;
        idPkg::exBundleT ex;
    } expectT;

    logic            clk;
    logic            rstN;
    idPkg::wordT     inst;
    idPkg::wordT     pc;
    idPkg::wordT     regaRdData;
    idPkg::wordT     regbRdData;
    idPkg::regReadT  regaReq;
    idPkg::regReadT  regbReq;
    idPkg::jumpT     jump;
    idPkg::exBundleT ex;

    integer seed = 32'he1f0_6960;
    int     errorCount = 0;
    int     checkCount = 0;
    expectT want;
    expectT held;
    expectT idle;

    idStage dut_i (
        .clk        (clk),
        .rstN       (rstN),
        .inst       (inst),
        .pc         (pc),
        .regaRdData (regaRdData),
        .regbRdData (regbRdData),
        .regaReq    (regaReq),
        .regbReq    (regbReq),
        .jump       (jump),
        .ex         (ex)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod/2) clk = ~clk;
    end

    initial
    begin
        #((numInst + resetCycles + 10) * clkPeriod);
        $display("timeout: the run did not finish in time, %0d errors so far", errorCount);
        $display("Verification failed");
        $finish;
    end

    function automatic expectT modelInst(input idPkg::wordT ins, input idPkg::wordT pcIn,
                                         input idPkg::wordT ra, input idPkg::wordT rb);
        expectT         e;
        idPkg::exOpT    code;
        idPkg::wordT    npc;
        idPkg::wordT    sext;
        idPkg::wordT    imm;
        idPkg::wordT    target;
        idPkg::regAddrT dst;
        logic           rtype;
        logic           useA;
        logic           useB;
        logic           wr;
        logic           taken;
        e = '0;
        imm = '0;
        target = '0;
        dst = '0;
        {useA, useB, wr, taken} = 4'b0000;
        npc = pcIn + 32'd4;
        sext = {{16{ins[15]}}, ins[15:0]};
        rtype = (ins[31:26] == idPkg::opSpecial);
        if (rtype)
        begin
            case (ins[5:0])
                idPkg::fnAdd:  code = idPkg::exAdd;
                idPkg::fnSub:  code = idPkg::exSub;
                idPkg::fnAnd:  code = idPkg::exAnd;
                idPkg::fnOr:   code = idPkg::exOr;
                idPkg::fnXor:  code = idPkg::exXor;
                idPkg::fnSlt:  code = idPkg::exSlt;
                idPkg::fnSll:  code = idPkg::exSll;
                idPkg::fnSrl:  code = idPkg::exSrl;
                idPkg::fnSra:  code = idPkg::exSra;
                idPkg::fnJr:   code = idPkg::exJr;
                idPkg::fnJalr: code = idPkg::exJalr;
                default:       code = idPkg::exNop;
            endcase
        end
        else
        begin
            case (ins[31:26])
                idPkg::opAddi:   code = idPkg::exAdd;
                idPkg::opAndi:   code = idPkg::exAnd;
                idPkg::opOri:    code = idPkg::exOr;
                idPkg::opXori:   code = idPkg::exXor;
                idPkg::opLui:    code = idPkg::exLui;
                idPkg::opLw:     code = idPkg::exLw;
                idPkg::opSw:     code = idPkg::exSw;
                idPkg::opJ:      code = idPkg::exJ;
                idPkg::opJal:    code = idPkg::exJal;
                idPkg::opBeq:    code = idPkg::exBeq;
                idPkg::opBne:    code = idPkg::exBne;
                idPkg::opBgtz:   code = idPkg::exBgtz;
                idPkg::opRegimm: code = idPkg::exBltz;
                default:         code = idPkg::exNop;
            endcase
        end
        case (code)
            idPkg::exAdd, idPkg::exSub, idPkg::exAnd, idPkg::exOr, idPkg::exXor, idPkg::exSlt:
            begin
                {useA, useB, wr} = rtype ? 3'b111 : 3'b101;
                dst = rtype ? ins[15:11] : ins[20:16];
                imm = rtype ? 32'h0 : {16'h0, ins[15:0]};   // addi zero-extends as well
            end
            idPkg::exSll, idPkg::exSrl, idPkg::exSra:
            begin
                {useA, useB, wr} = 3'b011;
                dst = ins[15:11];
                imm = {27'h0, ins[10:6]};
            end
            idPkg::exLui:
            begin
                wr = 1'b1;
                dst = ins[20:16];
                imm = {ins[15:0], 16'h0};
            end
            idPkg::exLw, idPkg::exSw:
            begin
                {useA, useB, wr} = (code == idPkg::exSw) ? 3'b110 : 3'b101;
                dst = ins[20:16];
                imm = sext;
            end
            idPkg::exJ, idPkg::exJal:
            begin
                {wr, taken} = {code == idPkg::exJal, 1'b1};
                dst = idPkg::linkReg;
                imm = (code == idPkg::exJal) ? npc : 32'h0;
                target = {npc[31:28], ins[25:0], 2'b00};
            end
            idPkg::exJr, idPkg::exJalr:
            begin
                {useA, wr, taken} = {1'b1, code == idPkg::exJalr, 1'b1};
                dst = ins[15:11];
                imm = (code == idPkg::exJalr) ? npc : 32'h0;
                target = ra;
            end
            idPkg::exBeq, idPkg::exBne:
            begin
                {useA, useB} = 2'b11;
                taken = ((ra == rb) == (code == idPkg::exBeq));
                target = npc + (sext << 2);
            end
            idPkg::exBgtz, idPkg::exBltz:
            begin
                useA = 1'b1;
                taken = (code == idPkg::exBgtz) ? ($signed(ra) > 0) : ($signed(ra) < 0);
                target = npc + (sext << 2);
            end
            default: ;
        endcase
        e.aReq = '{en: useA, addr: useA ? ins[25:21] : 5'd0};
        e.bReq = '{en: useB, addr: useB ? ins[20:16] : 5'd0};
        e.jump = '{jCe: taken, jAddr: target};
        e.ex.exOp = code;
        e.ex.regaData = (code == idPkg::exLw || code == idPkg::exSw) ? ra + imm : (useA ? ra : imm);
        e.ex.regbData = useB ? rb : imm;
        e.ex.regcWrite = wr;
        e.ex.regcAddr = wr ? dst : 5'd0;
        return e;
    endfunction

    task automatic driveRandom();
        int pick;
        inst = $random(seed);
        pick = {$random(seed)} % 10;
        if (pick == 0)
        begin
            if ($random(seed) & 1)
                inst[31:0] = {idPkg::opSpecial, inst[25:6], unusedFns[({$random(seed)} % 8)*6 +: 6]};
            else
                inst[31:26] = unusedOps[({$random(seed)} % 8)*6 +: 6];
        end
        else
        begin
            pick = {$random(seed)} % 24;
            if (pick < 11)
                inst[31:0] = {idPkg::opSpecial, inst[25:6], keptFns[pick*6 +: 6]};
            else
                inst[31:26] = keptOps[(pick-11)*6 +: 6];
        end
        pc = $random(seed) & 32'hffff_fffc;
        regaRdData = $random(seed);
        regbRdData = $random(seed);
        if ({$random(seed)} % 4 == 0)
            regaRdData = {$random(seed)} % 3 - 1;   // -1, 0 or +1 for the signed branches
        if ({$random(seed)} % 4 == 0)
            regbRdData = regaRdData;
    endtask

    task automatic checkField(input string what, input logic [79:0] got, input logic [79:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            errorCount++;
            $display("[ERROR] %0t ns: %s is %0h, expected %0h (inst %h)", $time, what, got, exp,
                     inst);
        end
    endtask

    task automatic checkComb(input expectT e);
        checkField("regaReq", regaReq, e.aReq);
        checkField("regbReq", regbReq, e.bReq);
        checkField("jump.jCe", jump.jCe, e.jump.jCe);
        if (e.jump.jCe)
            checkField("jump.jAddr", jump.jAddr, e.jump.jAddr);
    endtask

    task automatic checkBundle(input expectT e);
        checkField("ex.exOp", ex.exOp, e.ex.exOp);
        checkField("ex.regaData", ex.regaData, e.ex.regaData);
        checkField("ex.regbData", ex.regbData, e.ex.regbData);
        checkField("ex.regcWrite", ex.regcWrite, e.ex.regcWrite);
        checkField("ex.regcAddr", ex.regcAddr, e.ex.regcAddr);
    endtask

    initial
    begin
        rstN = 1'b0;
        inst = '0;
        pc = '0;
        regaRdData = '0;
        regbRdData = '0;
        idle = '0;
        repeat (resetCycles)
        begin
            driveRandom();
            #(clkPeriod/2 - 2);
            checkComb(idle);
            @(negedge clk);
        end
        checkBundle(idle);
        rstN = 1'b1;
        for (int i = 0; i < numInst; i++)
        begin
            if (i > 0)
            begin
                @(negedge clk);
                checkBundle(held);   // bundle of the instruction sampled at the last edge
            end
            driveRandom();
            want = modelInst(inst, pc, regaRdData, regbRdData);
            #(clkPeriod/2 - 2);
            checkComb(want);
            held = want;
        end
        @(negedge clk);
        checkBundle(held);
        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/idStage_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module idStageSva (
    input logic            clk,
    input logic            rstN,
    input idPkg::jumpT     jump,
    input idPkg::exBundleT ex
);

    // a reset edge leaves the nop bundle behind
    resetClearsWrite: assert property (@(posedge clk) !rstN |=> !ex.regcWrite)
        else $error("ex.regcWrite is high after a clock edge in reset");

    noJumpInReset: assert property (@(posedge clk) !rstN |-> !jump.jCe)
        else $error("jump.jCe is high while rstN is low");

    nopWritesNothing: assert property (@(posedge clk) (ex.exOp == idPkg::exNop) |-> !ex.regcWrite)
        else $error("ex carries exNop with regcWrite high");

endmodule

bind idStage idStageSva sva_i (
    .clk  (clk),
    .rstN (rstN),
    .jump (jump),
    .ex   (ex)
);

`default_nettype wire
